/* fpu_top.f */
fpu_pkg.sv
fp_round_pack.sv
fp_add_unit.sv
fp_mul_unit.sv
fpu_issue_ctrl.sv
fpu_top.sv
tb_fpu_top.sv

/* Bender.yml */
package:
  name: fpu_top

sources:
  - fpu_pkg.sv
  - fp_round_pack.sv
  - fp_add_unit.sv
  - fp_mul_unit.sv
  - fpu_issue_ctrl.sv
  - fpu_top.sv
  - target: simulation
    files:
      - tb_fpu_top.sv

/* tb_fpu_top.sv */
//======================================================================
// fpu testbench
// table of operations with expected words, flags and latency checks
//======================================================================
`timescale 1ns/1ps

module tb_fpu_top;
    import fpu_pkg::*;

    localparam int NUM_TESTS = 14;
    localparam longint WATCHDOG_NS = (NUM_TESTS * (ADD_LATENCY + 6) + 10) * 100;

    localparam fp_flags_t FLG_NONE = 4'b0000;
    localparam fp_flags_t FLG_NV   = 4'b1000;
    localparam fp_flags_t FLG_OFNX = 4'b0101;
    localparam fp_flags_t FLG_UFNX = 4'b0011;
    localparam fp_flags_t FLG_NX   = 4'b0001;

    typedef struct packed {
        fp_op_e    op;
        rm_e       rm;
        fp_word_t  a;
        fp_word_t  b;
        fp_word_t  res;
        fp_flags_t flags;
    } test_vec_t;

    logic     clk = 1'b0;
    logic     rst;
    logic     req_valid_i;
    fpu_req_t req_i;
    logic     req_taken_o;
    logic     rsp_valid_o;
    fpu_rsp_t rsp_o;

    test_vec_t tbl [NUM_TESTS];
    string     names [NUM_TESTS];
    int        pend_idx [$];
    int        pend_cyc [$];
    int        cycle_cnt = 0;
    int        tests_checked = 0;

    fpu_top fpu_top_inst (
        .clk         (clk),
        .rst         (rst),
        .req_valid_i (req_valid_i),
        .req_i       (req_i),
        .req_taken_o (req_taken_o),
        .rsp_valid_o (rsp_valid_o),
        .rsp_o       (rsp_o)
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("TEST FAIL");
        $fatal(1);
    endtask

    task automatic check_result(input string name, input fp_word_t exp_w, input fp_word_t act_w);
        if (act_w !== exp_w) begin
            abort_run($sformatf("[ERROR] %s: result expected %h, actual %h",
                                name, exp_w, act_w));
        end
    endtask

    task automatic check_flags(input string name, input fp_flags_t exp_f,
                               input fp_flags_t act_f);
        if (act_f !== exp_f) begin
            abort_run($sformatf("[ERROR] %s: flags expected %b, actual %b",
                                name, exp_f, act_f));
        end
    endtask

    // add and subtract go through the deeper adder pipeline
    function automatic int latency_of(input fp_op_e op);
        return (op == OP_MUL) ? MUL_LATENCY : ADD_LATENCY;
    endfunction

    task automatic set_vec(input int i, input string name, input fp_op_e op, input rm_e rm,
                           input fp_word_t a, input fp_word_t b, input fp_word_t res,
                           input fp_flags_t flags);
        names[i]     = name;
        tbl[i].op    = op;
        tbl[i].rm    = rm;
        tbl[i].a     = a;
        tbl[i].b     = b;
        tbl[i].res   = res;
        tbl[i].flags = flags;
    endtask

    task automatic load_table();
        set_vec(0, "add_exact", OP_ADD, RM_RNE, 32'h3FC00000, 32'h40100000, 32'h40700000, FLG_NONE);
        set_vec(1, "sub_cancel", OP_SUB, RM_RNE, 32'h3F800000, 32'h3F800000, 32'h00000000, FLG_NONE);
        set_vec(2, "mul_exact", OP_MUL, RM_RNE, 32'h3FC00000, 32'h40000000, 32'h40400000, FLG_NONE);
        // b is exactly half an ulp of a
        set_vec(3, "tie_rne", OP_ADD, RM_RNE, 32'h3F800000, 32'h33800000, 32'h3F800000, FLG_NX);
        set_vec(4, "tie_rtz", OP_ADD, RM_RTZ, 32'h3F800000, 32'h33800000, 32'h3F800000, FLG_NX);
        set_vec(5, "tie_rdn", OP_ADD, RM_RDN, 32'h3F800000, 32'h33800000, 32'h3F800000, FLG_NX);
        set_vec(6, "tie_rup", OP_ADD, RM_RUP, 32'h3F800000, 32'h33800000, 32'h3F800001, FLG_NX);
        set_vec(7, "tie_rmm", OP_ADD, RM_RMM, 32'h3F800000, 32'h33800000, 32'h3F800001, FLG_NX);
        set_vec(8, "ovf_rne", OP_MUL, RM_RNE, 32'h7F000000, 32'h7F000000, 32'h7F800000, FLG_OFNX);
        set_vec(9, "ovf_rtz", OP_MUL, RM_RTZ, 32'h7F000000, 32'h7F000000, 32'h7F7FFFFF, FLG_OFNX);
        set_vec(10, "nan_in", OP_ADD, RM_RNE, 32'h7FC00001, 32'h3F800000, QNAN, FLG_NV);
        set_vec(11, "inf_minus_inf", OP_SUB, RM_RNE, 32'h7F800000, 32'h7F800000, QNAN, FLG_NV);
        set_vec(12, "inf_times_zero", OP_MUL, RM_RNE, 32'h7F800000, 32'h00000000, QNAN, FLG_NV);
        set_vec(13, "mul_underflow", OP_MUL, RM_RNE, 32'h00800000, 32'h3F000000, 32'h00000000,
                FLG_UFNX);
    endtask

    //==================================================================
    // response monitor sampled mid cycle
    //==================================================================
    always @(negedge clk) begin : monitor
        int idx;
        int acc;
        if (!rst) begin
            if (rsp_valid_o === 1'b1) begin
                if (pend_idx.size() == 0) begin
                    abort_run("a response appeared with no request outstanding");
                end
                idx = pend_idx.pop_front();
                acc = pend_cyc.pop_front();
                if (cycle_cnt - acc != latency_of(tbl[idx].op)) begin
                    abort_run($sformatf("response for %s arrived %0d cycles after acceptance",
                                        names[idx], cycle_cnt - acc));
                end
                check_result(names[idx], tbl[idx].res, rsp_o.word);
                check_flags(names[idx], tbl[idx].flags, rsp_o.flags);
                tests_checked++;
            end else if (pend_idx.size() != 0) begin
                if (cycle_cnt - pend_cyc[0] >= latency_of(tbl[pend_idx[0]].op)) begin
                    abort_run($sformatf("no response for %s when it was due",
                                        names[pend_idx[0]]));
                end
            end
        end
    end

    initial begin : watchdog
        #(WATCHDOG_NS);
        $display("timeout: the run did not finish in the expected time");
        $display("TEST FAIL");
        $fatal(1);
    end

    //==================================================================
    // request driver
    //==================================================================
    initial begin : driver
        int gap;
        int rand_init;
        int due;
        rst         = 1'b1;
        req_valid_i = 1'b0;
        req_i       = '0;
        due         = 0;
        rand_init   = $urandom(91);
        load_table();
        repeat (2) @(posedge clk);
        #1 rst = 1'b0;
        @(negedge clk);
        if (rsp_valid_o !== 1'b0 || req_taken_o !== 1'b0) begin
            abort_run("rsp_valid_o or req_taken_o not low after reset");
        end
        @(posedge clk);
        #1;
        for (int i = 0; i < NUM_TESTS; i++) begin
            // every third request back to back and held while busy
            gap = (i % 3 == 2) ? 0 : $urandom % 4;
            repeat (gap) begin
                @(posedge clk);
                #1;
            end
            req_valid_i = 1'b1;
            req_i.op    = tbl[i].op;
            req_i.rm    = tbl[i].rm;
            req_i.a     = tbl[i].a;
            req_i.b     = tbl[i].b;
            do begin
                @(negedge clk);
                if (req_taken_o !== (cycle_cnt >= due)) begin
                    abort_run($sformatf("req_taken_o wrong while holding %s at cycle %0d",
                                        names[i], cycle_cnt));
                end
            end while (req_taken_o !== 1'b1);
            pend_idx.push_back(i);
            pend_cyc.push_back(cycle_cnt);
            due = cycle_cnt + latency_of(tbl[i].op);
            @(posedge clk);
            #1 req_valid_i = 1'b0;
        end
        wait (tests_checked == NUM_TESTS);
        repeat (6) @(negedge clk);
        if (tests_checked == NUM_TESTS && pend_idx.size() == 0) begin
            $display("TEST PASS");
            $finish;
        end else begin
            $display("extra or missing responses at the end of the run");
            $display("TEST FAIL");
            $fatal(1);
        end
    end

endmodule

/* fpu_top.sv */
//======================================================================
// fpu top level
// issue controller with one adder and one multiplier behind it
//======================================================================
`timescale 1ns/1ps

module fpu_top (
    input  logic              clk,
    input  logic              rst,
    input  logic              req_valid_i,
    input  fpu_pkg::fpu_req_t req_i,
    output logic              req_taken_o,
    output logic              rsp_valid_o,
    output fpu_pkg::fpu_rsp_t rsp_o
);
    import fpu_pkg::*;

    logic      add_start;
    logic      mul_start;
    logic      add_valid;
    logic      mul_valid;
    unit_req_t unit_req;
    fpu_rsp_t  add_rsp;
    fpu_rsp_t  mul_rsp;

    fpu_issue_ctrl ctrl_inst (
        .clk         (clk),
        .rst         (rst),
        .req_valid_i (req_valid_i),
        .req_i       (req_i),
        .add_valid_i (add_valid),
        .add_rsp_i   (add_rsp),
        .mul_valid_i (mul_valid),
        .mul_rsp_i   (mul_rsp),
        .req_taken_o (req_taken_o),
        .add_start_o (add_start),
        .mul_start_o (mul_start),
        .unit_req_o  (unit_req),
        .rsp_valid_o (rsp_valid_o),
        .rsp_o       (rsp_o)
    );

    fp_add_unit add_inst (
        .clk     (clk),
        .rst     (rst),
        .start_i (add_start),
        .req_i   (unit_req),
        .valid_o (add_valid),
        .rsp_o   (add_rsp)
    );

    fp_mul_unit mul_inst (
        .clk     (clk),
        .rst     (rst),
        .start_i (mul_start),
        .req_i   (unit_req),
        .valid_o (mul_valid),
        .rsp_o   (mul_rsp)
    );

endmodule

/* fpu_issue_ctrl.sv */
//======================================================================
// fpu issue controller
// accepts one request at a time, dispatches it, forwards the result
//======================================================================
`timescale 1ns/1ps

module fpu_issue_ctrl (
    input  logic               clk,
    input  logic               rst,
    input  logic               req_valid_i,
    input  fpu_pkg::fpu_req_t  req_i,
    input  logic               add_valid_i,
    input  fpu_pkg::fpu_rsp_t  add_rsp_i,
    input  logic               mul_valid_i,
    input  fpu_pkg::fpu_rsp_t  mul_rsp_i,
    output logic               req_taken_o,
    output logic               add_start_o,
    output logic               mul_start_o,
    output fpu_pkg::unit_req_t unit_req_o,
    output logic               rsp_valid_o,
    output fpu_pkg::fpu_rsp_t  rsp_o
);
    import fpu_pkg::*;

    typedef enum logic {
        S_IDLE,
        S_BUSY
    } state_e;

    state_e state_q;
    state_e state_d;
    logic   done;

    // outstanding op finishes when either unit answers
    assign done        = add_valid_i | mul_valid_i;
    assign req_taken_o = req_valid_i & ((state_q == S_IDLE) | done);

    always_comb begin
        state_d = state_q;
        if (req_taken_o) begin
            state_d = S_BUSY;
        end else if (done) begin
            state_d = S_IDLE;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= S_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // dispatch
    assign add_start_o = req_taken_o & (req_i.op != OP_MUL);
    assign mul_start_o = req_taken_o & (req_i.op == OP_MUL);

    always_comb begin
        unit_req_o.rm = req_i.rm;
        unit_req_o.a  = req_i.a;
        unit_req_o.b  = req_i.b;
        // subtract is an add with b negated
        if (req_i.op == OP_SUB) begin
            unit_req_o.b[FP_W-1] = ~req_i.b[FP_W-1];
        end
    end

    // result select
    assign rsp_valid_o = done;
    assign rsp_o       = add_valid_i ? add_rsp_i : mul_rsp_i;

endmodule

/* fp_mul_unit.sv */
//======================================================================
// binary32 multiplier
// three stage multiply: classify, product and normalize, round
//======================================================================
`timescale 1ns/1ps

module fp_mul_unit (
    input  logic               clk,
    input  logic               rst,
    input  logic               start_i,
    input  fpu_pkg::unit_req_t req_i,
    output logic               valid_o,
    output fpu_pkg::fpu_rsp_t  rsp_o
);
    import fpu_pkg::*;

    logic             a_s, b_s;
    logic [EXP_W-1:0] a_e, b_e;
    logic [MAN_W-1:0] a_m, b_m;
    logic             a_zero, b_zero, a_inf, b_inf, a_nan, b_nan;
    logic             take_d;
    fpu_rsp_t         spc_d;

    logic               v0, v1;
    logic               take_q0, take_q1;
    fpu_rsp_t           spc_q0, spc_q1;
    rm_e                rm_q0, rm_q1;
    logic               sign_q0;
    logic signed [9:0]  exp_q0;
    logic [SIG_W-1:0]   sig_a_q0, sig_b_q0;
    logic [2*SIG_W-1:0] prod;
    round_in_t          rin_d, rin_q1;
    fp_word_t           rnd_word;
    fp_flags_t          rnd_flags;

    //==================================================================
    // stage 0: classify, sign, exponent sum
    //==================================================================
    assign {a_s, a_e, a_m} = req_i.a;
    assign {b_s, b_e, b_m} = req_i.b;
    assign a_zero = (a_e == '0);
    assign b_zero = (b_e == '0);
    assign a_inf  = (a_e == EXP_W'(EXP_MAX)) && (a_m == '0);
    assign b_inf  = (b_e == EXP_W'(EXP_MAX)) && (b_m == '0);
    assign a_nan  = (a_e == EXP_W'(EXP_MAX)) && (a_m != '0);
    assign b_nan  = (b_e == EXP_W'(EXP_MAX)) && (b_m != '0);

    always_comb begin
        take_d = 1'b1;
        spc_d  = '0;
        if (a_nan || b_nan || (a_inf && b_zero) || (b_inf && a_zero)) begin
            spc_d.word     = QNAN;
            spc_d.flags.nv = 1'b1;
        end else if (a_inf || b_inf) begin
            spc_d.word = {a_s ^ b_s, {EXP_W{1'b1}}, {MAN_W{1'b0}}};
        end else if (a_zero || b_zero) begin
            spc_d.word = {a_s ^ b_s, {(FP_W-1){1'b0}}};
        end else begin
            take_d = 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (start_i) begin
            take_q0  <= take_d;
            spc_q0   <= spc_d;
            rm_q0    <= req_i.rm;
            sign_q0  <= a_s ^ b_s;
            exp_q0   <= 10'(a_e) + 10'(b_e) - 10'(EXP_BIAS);
            sig_a_q0 <= {1'b1, a_m};
            sig_b_q0 <= {1'b1, b_m};
        end
    end

    //==================================================================
    // stage 1: product, one position normalize, fold grs
    //==================================================================
    assign prod = sig_a_q0 * sig_b_q0;

    always_comb begin
        rin_d.sign = sign_q0;
        // product in [2,4) moves up one binade
        if (prod[2*SIG_W-1]) begin
            rin_d.exp = exp_q0 + 10'sd1;
            rin_d.sig = prod[2*SIG_W-1 -: SIG_W];
            rin_d.grs = {prod[SIG_W-1], prod[SIG_W-2], |prod[SIG_W-3:0]};
        end else begin
            rin_d.exp = exp_q0;
            rin_d.sig = prod[2*SIG_W-2 -: SIG_W];
            rin_d.grs = {prod[SIG_W-2], prod[SIG_W-3], |prod[SIG_W-4:0]};
        end
    end

    always_ff @(posedge clk) begin
        if (v0) begin
            take_q1 <= take_q0;
            spc_q1  <= spc_q0;
            rm_q1   <= rm_q0;
            rin_q1  <= rin_d;
        end
    end

    //==================================================================
    // stage 2: round and output register
    //==================================================================
    fp_round_pack round_inst (
        .val_i   (rin_q1),
        .rm_i    (rm_q1),
        .word_o  (rnd_word),
        .flags_o (rnd_flags)
    );

    always_ff @(posedge clk) begin
        if (v1) begin
            rsp_o <= take_q1 ? spc_q1 : {rnd_word, rnd_flags};
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            v0      <= 1'b0;
            v1      <= 1'b0;
            valid_o <= 1'b0;
        end else begin
            v0      <= start_i;
            v1      <= v0;
            valid_o <= v1;
        end
    end

endmodule

/* fp_add_unit.sv */
//======================================================================
// binary32 adder
// four stage add/subtract: classify, align, normalize, round
//======================================================================
`timescale 1ns/1ps

module fp_add_unit (
    input  logic               clk,
    input  logic               rst,
    input  logic               start_i,
    input  fpu_pkg::unit_req_t req_i,
    output logic               valid_o,
    output fpu_pkg::fpu_rsp_t  rsp_o
);
    import fpu_pkg::*;

    localparam int EXT_W = SIG_W + 3;
    localparam int SUM_W = EXT_W + 1;
    localparam int LZ_W  = $clog2(SUM_W);

    logic             a_s, b_s, a_ge;
    logic [EXP_W-1:0] a_e, b_e;
    logic [MAN_W-1:0] a_m, b_m;
    logic             a_zero, b_zero, a_inf, b_inf, a_nan, b_nan;
    logic             take_d;
    fpu_rsp_t         spc_d;

    logic             v0, v1, v2;
    logic             take_q0, take_q1, take_q2;
    fpu_rsp_t         spc_q0, spc_q1, spc_q2;
    rm_e              rm_q0, rm_q1, rm_q2;
    logic             sign_q0, sign_q1, sign_q2;
    logic             sub_q0;
    logic [EXP_W-1:0] big_e_q0, big_e_q1, diff_q0;
    logic [SIG_W-1:0] big_m_q0, small_m_q0;

    logic [2*EXT_W-1:0] shift_full;
    logic [EXT_W-1:0]   aligned;
    logic [SUM_W-1:0]   sum_d, sum_q1;
    logic [LZ_W-1:0]    lz;
    logic [SUM_W-1:0]   norm_q2;
    logic signed [9:0]  exp_q2;
    round_in_t          rin;
    fp_word_t           rnd_word;
    fp_flags_t          rnd_flags;

    //==================================================================
    // stage 0 unpacks, classifies and orders by magnitude
    //==================================================================
    assign {a_s, a_e, a_m} = req_i.a;
    assign {b_s, b_e, b_m} = req_i.b;
    // subnormals read as zero
    assign a_zero = (a_e == '0);
    assign b_zero = (b_e == '0);
    assign a_inf  = (a_e == EXP_W'(EXP_MAX)) && (a_m == '0);
    assign b_inf  = (b_e == EXP_W'(EXP_MAX)) && (b_m == '0);
    assign a_nan  = (a_e == EXP_W'(EXP_MAX)) && (a_m != '0);
    assign b_nan  = (b_e == EXP_W'(EXP_MAX)) && (b_m != '0);
    assign a_ge   = {a_e, a_m} >= {b_e, b_m};

    always_comb begin
        take_d = 1'b1;
        spc_d  = '0;
        if (a_nan || b_nan || (a_inf && b_inf && (a_s != b_s))) begin
            spc_d.word     = QNAN;
            spc_d.flags.nv = 1'b1;
        end else if (a_inf || (b_zero && !a_zero)) begin
            spc_d.word = req_i.a;
        end else if (b_inf || (a_zero && !b_zero)) begin
            spc_d.word = req_i.b;
        end else if (a_zero) begin
            spc_d.word = {a_s & b_s, {(FP_W-1){1'b0}}};
        end else begin
            take_d = 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (start_i) begin
            take_q0    <= take_d;
            spc_q0     <= spc_d;
            rm_q0      <= req_i.rm;
            sign_q0    <= a_ge ? a_s : b_s;
            sub_q0     <= a_s ^ b_s;
            big_e_q0   <= a_ge ? a_e : b_e;
            diff_q0    <= a_ge ? a_e - b_e : b_e - a_e;
            big_m_q0   <= a_ge ? {1'b1, a_m} : {1'b1, b_m};
            small_m_q0 <= a_ge ? {1'b1, b_m} : {1'b1, a_m};
        end
    end

    //==================================================================
    // stage 1 aligns with sticky and adds or subtracts
    //==================================================================
    always_comb begin
        if (diff_q0 >= EXT_W) begin
            shift_full = {{EXT_W{1'b0}}, small_m_q0, 3'b000};
        end else begin
            shift_full = {small_m_q0, 3'b000, {EXT_W{1'b0}}} >> diff_q0;
        end
        aligned = {shift_full[2*EXT_W-1:EXT_W+1],
                   shift_full[EXT_W] | (|shift_full[EXT_W-1:0])};
        // big >= small, so the difference never goes negative
        if (sub_q0) begin
            sum_d = {1'b0, big_m_q0, 3'b000} - {1'b0, aligned};
        end else begin
            sum_d = {1'b0, big_m_q0, 3'b000} + {1'b0, aligned};
        end
    end

    always_ff @(posedge clk) begin
        if (v0) begin
            take_q1  <= take_q0;
            spc_q1   <= spc_q0;
            rm_q1    <= rm_q0;
            sign_q1  <= sign_q0;
            big_e_q1 <= big_e_q0;
            sum_q1   <= sum_d;
        end
    end

    //==================================================================
    // stage 2 counts leading zeros and normalizes
    //==================================================================
    always_comb begin
        lz = '0;
        for (int i = 0; i < SUM_W; i++) begin
            if (sum_q1[i]) begin
                lz = LZ_W'(SUM_W - 1 - i);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (v1) begin
            // exact cancellation gives +0
            take_q2 <= take_q1 | (sum_q1 == '0);
            spc_q2  <= take_q1 ? spc_q1 : '0;
            rm_q2   <= rm_q1;
            sign_q2 <= sign_q1;
            norm_q2 <= sum_q1 << lz;
            exp_q2  <= 10'(big_e_q1) + 10'sd1 - 10'(lz);
        end
    end

    //==================================================================
    // stage 3 rounds and loads the output register
    //==================================================================
    assign rin.sign = sign_q2;
    assign rin.exp  = exp_q2;
    assign rin.sig  = norm_q2[SUM_W-1 -: SIG_W];
    assign rin.grs  = {norm_q2[3], norm_q2[2], |norm_q2[1:0]};

    fp_round_pack round_inst (
        .val_i   (rin),
        .rm_i    (rm_q2),
        .word_o  (rnd_word),
        .flags_o (rnd_flags)
    );

    always_ff @(posedge clk) begin
        if (v2) begin
            rsp_o <= take_q2 ? spc_q2 : {rnd_word, rnd_flags};
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            v0      <= 1'b0;
            v1      <= 1'b0;
            v2      <= 1'b0;
            valid_o <= 1'b0;
        end else begin
            v0      <= start_i;
            v1      <= v0;
            v2      <= v1;
            valid_o <= v2;
        end
    end

endmodule

/* fp_round_pack.sv */
//======================================================================
// binary32 rounder
// rounds an unrounded significand, handles overflow and flush to zero
//======================================================================
`timescale 1ns/1ps

module fp_round_pack (
    input  fpu_pkg::round_in_t val_i,
    input  fpu_pkg::rm_e       rm_i,
    output fpu_pkg::fp_word_t  word_o,
    output fpu_pkg::fp_flags_t flags_o
);
    import fpu_pkg::*;

    logic              inexact;
    logic              inc;
    logic [SIG_W:0]    sig_inc;
    logic signed [9:0] exp_r;
    logic [MAN_W-1:0]  man_r;
    fp_word_t          max_fin;
    fp_word_t          inf;

    assign inexact = |val_i.grs;

    always_comb begin
        case (rm_i)
            RM_RTZ:  inc = 1'b0;
            RM_RDN:  inc = val_i.sign & inexact;
            RM_RUP:  inc = ~val_i.sign & inexact;
            RM_RMM:  inc = val_i.grs[2];
            // rne, also reserved and dynamic codes
            default: inc = val_i.grs[2] & (val_i.grs[1] | val_i.grs[0] | val_i.sig[0]);
        endcase
    end

    // carry out leaves a zero fraction one binade up
    assign sig_inc = {1'b0, val_i.sig} + {{SIG_W{1'b0}}, inc};
    assign exp_r   = val_i.exp + 10'(sig_inc[SIG_W]);
    assign man_r   = sig_inc[SIG_W] ? '0 : sig_inc[MAN_W-1:0];

    assign max_fin = {val_i.sign, EXP_W'(EXP_MAX - 1), {MAN_W{1'b1}}};
    assign inf     = {val_i.sign, {EXP_W{1'b1}}, {MAN_W{1'b0}}};

    always_comb begin
        flags_o    = '0;
        flags_o.nx = inexact;
        word_o     = {val_i.sign, exp_r[EXP_W-1:0], man_r};
        if (val_i.exp <= 10'sd0) begin
            word_o     = {val_i.sign, {(FP_W-1){1'b0}}};
            flags_o.uf = 1'b1;
            flags_o.nx = 1'b1;
        end else if (exp_r >= EXP_MAX) begin
            flags_o.of = 1'b1;
            flags_o.nx = 1'b1;
            case (rm_i)
                RM_RTZ:  word_o = max_fin;
                RM_RDN:  word_o = val_i.sign ? inf : max_fin;
                RM_RUP:  word_o = val_i.sign ? max_fin : inf;
                default: word_o = inf;
            endcase
        end
    end

endmodule

/* fpu_pkg.sv */
//======================================================================
// fpu shared definitions
// binary32 widths, encodings and the request/response structs
//======================================================================
package fpu_pkg;

    localparam int FP_W  = 32;
    localparam int EXP_W = 8;
    localparam int MAN_W = 23;
    localparam int SIG_W = MAN_W + 1;

    localparam int EXP_BIAS = 127;
    localparam int EXP_MAX  = 255;

    localparam int ADD_LATENCY = 4;
    localparam int MUL_LATENCY = 3;

    typedef logic [FP_W-1:0] fp_word_t;

    localparam fp_word_t QNAN = 32'h7FC0_0000;

    typedef enum logic [1:0] {
        OP_ADD = 2'd0,
        OP_SUB = 2'd1,
        OP_MUL = 2'd2
    } fp_op_e;

    // risc-v encoding, other codes fall back to rne
    typedef enum logic [2:0] {
        RM_RNE = 3'b000,
        RM_RTZ = 3'b001,
        RM_RDN = 3'b010,
        RM_RUP = 3'b011,
        RM_RMM = 3'b100
    } rm_e;

    typedef struct packed {
        logic nv;
        logic of;
        logic uf;
        logic nx;
    } fp_flags_t;

    typedef struct packed {
        fp_op_e   op;
        rm_e      rm;
        fp_word_t a;
        fp_word_t b;
    } fpu_req_t;

    typedef struct packed {
        rm_e      rm;
        fp_word_t a;
        fp_word_t b;
    } unit_req_t;

    typedef struct packed {
        fp_word_t  word;
        fp_flags_t flags;
    } fpu_rsp_t;

    // unrounded value, leading one at sig msb
    typedef struct packed {
        logic              sign;
        logic signed [9:0] exp;
        logic [SIG_W-1:0]  sig;
        logic [2:0]        grs;
    } round_in_t;

endpackage
